/* common/fetch_pkg.sv */
package fetch_pkg;

  ////////////////////////////////////////
  // machine widths
  ////////////////////////////////////////

  localparam int PC_W         = 64;
  localparam int INST_W       = 32;

  // one fetch bundle is eight aligned words
  localparam int SLOTS        = 8;
  localparam int SLOT_W       = $clog2(SLOTS);
  localparam int BUNDLE_BYTES = 32;

  ////////////////////////////////////////
  // branch format
  ////////////////////////////////////////

  // opcode sits in the top six bits, displacement in the low 21
  localparam int OPC_W  = 6;
  localparam int DISP_W = 21;

  // unconditional branch and branch-to-subroutine
  localparam logic [OPC_W-1:0] OPC_BR  = 6'h30;
  localparam logic [OPC_W-1:0] OPC_BSR = 6'h34;

  typedef logic [PC_W-1:0]   pc_t;
  typedef logic [INST_W-1:0] inst_t;
  typedef logic [SLOT_W-1:0] slot_t;
  typedef logic [SLOTS-1:0]  slot_mask_t;

  // f0 lookup result
  typedef struct packed {
    logic  hit;
    slot_t pos;
    pc_t   target;
  } btb_pred_t;

  // f1 scan result, first unconditional branch only
  typedef struct packed {
    logic  found;
    slot_t pos;
    pc_t   target;
  } br_decode_t;

  // training request, pc is the bundle address
  typedef struct packed {
    logic  we;
    pc_t   pc;
    slot_t pos;
    pc_t   target;
  } btb_write_t;

  // bit n of mask qualifies words[n]
  typedef struct packed {
    inst_t [SLOTS-1:0] words;
    slot_mask_t        mask;
  } fetch_bundle_t;

endpackage

/* btb/btb_predictor.sv */
`timescale 1ns/100ps

module btb_predictor #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                  clock,
  input  logic                  reset_n,
  input  fetch_pkg::pc_t        pc_f0_i,
  input  fetch_pkg::btb_write_t btb_write_i,
  output fetch_pkg::pc_t        next_pc_o,
  output fetch_pkg::btb_pred_t  pred_o
);

  import fetch_pkg::*;

  // pc split: tag | index | bundle offset
  localparam int OFFS_W = $clog2(BUNDLE_BYTES);
  localparam int IDX_W  = $clog2(BTB_ENTRIES);
  localparam int TAG_W  = PC_W - OFFS_W - IDX_W;

  typedef logic [IDX_W-1:0] btb_idx_t;
  typedef logic [TAG_W-1:0] btb_tag_t;

  // entry storage
  logic [BTB_ENTRIES-1:0] valid_q;
  btb_tag_t               tag_q    [BTB_ENTRIES];
  slot_t                  pos_q    [BTB_ENTRIES];
  pc_t                    target_q [BTB_ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;
  logic     lookup_hit;

  ////////////////////////////////////////
  // f0 lookup
  ////////////////////////////////////////

  assign rd_idx = pc_f0_i[OFFS_W +: IDX_W];
  assign rd_tag = pc_f0_i[PC_W-1 -: TAG_W];

  assign lookup_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  // position is what later cuts the bundle after the branch
  assign pred_o = '{
    hit:    lookup_hit,
    pos:    pos_q[rd_idx],
    target: target_q[rd_idx]
  };

  // taken target on a hit, else the next sequential bundle
  assign next_pc_o = lookup_hit ? target_q[rd_idx]
                                : pc_f0_i + pc_t'(BUNDLE_BYTES);

  ////////////////////////////////////////
  // training from f1
  ////////////////////////////////////////

  assign wr_idx = btb_write_i.pc[OFFS_W +: IDX_W];
  assign wr_tag = btb_write_i.pc[PC_W-1 -: TAG_W];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else if (btb_write_i.we) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // a write simply replaces whatever the entry held
  always_ff @(posedge clock) begin
    if (btb_write_i.we) begin
      tag_q[wr_idx]    <= wr_tag;
      pos_q[wr_idx]    <= btb_write_i.pos;
      target_q[wr_idx] <= btb_write_i.target;
    end
  end

endmodule

/* hdl/branch_decoder.sv */
`timescale 1ns/100ps

module branch_decoder (
  input  fetch_pkg::pc_t           pc_f1_i,
  input  fetch_pkg::fetch_bundle_t bundle_i,
  output fetch_pkg::br_decode_t    decode_o
);

  import fetch_pkg::*;

  ////////////////////////////////////////
  // branch format decode
  ////////////////////////////////////////

  // [31:26] opcode, [25:21] ra, [20:0] word displacement
  function automatic logic is_uncond_br(input inst_t inst);
    logic [OPC_W-1:0] opc;
    opc = inst[INST_W-1 -: OPC_W];
    return (opc == OPC_BR) || (opc == OPC_BSR);
  endfunction

  // target = updated pc + 4 * sext(disp)
  function automatic pc_t br_target(input pc_t slot_pc, input inst_t inst);
    logic [DISP_W-1:0] disp;
    pc_t               offset;
    disp   = inst[DISP_W-1:0];
    offset = {{(PC_W-DISP_W-2){disp[DISP_W-1]}}, disp, 2'b00};
    return slot_pc + pc_t'(4) + offset;
  endfunction

  slot_mask_t br_match;
  pc_t        slot_pc  [SLOTS];
  pc_t        slot_tgt [SLOTS];

  ////////////////////////////////////////
  // per-slot decode
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      slot_pc[i]  = pc_f1_i + pc_t'(4 * i);
      br_match[i] = is_uncond_br(bundle_i.words[i]);
      slot_tgt[i] = br_target(slot_pc[i], bundle_i.words[i]);
    end
  end

  ////////////////////////////////////////
  // priority pick
  ////////////////////////////////////////

  // walk down so the lowest matching slot is written last
  always_comb begin
    decode_o = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (br_match[i]) begin
        decode_o.found  = 1'b1;
        decode_o.pos    = slot_t'(i);
        decode_o.target = slot_tgt[i];
      end
    end
  end

endmodule

/* hdl/fetch_redirect.sv */
`timescale 1ns/100ps

module fetch_redirect (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic                     load_fetch_i,
  input  logic                     flush_i,
  input  logic                     icache_stall_i,
  input  fetch_pkg::pc_t           pc_f0_i,
  input  fetch_pkg::btb_pred_t     pred_i,
  input  fetch_pkg::br_decode_t    decode_i,
  input  fetch_pkg::fetch_bundle_t bundle_i,
  output fetch_pkg::pc_t           pc_f1_o,
  output fetch_pkg::btb_write_t    btb_write_o,
  output logic                     override_vld_o,
  output fetch_pkg::pc_t           override_pc_o,
  output fetch_pkg::fetch_bundle_t decode_bundle_o
);

  import fetch_pkg::*;

  localparam slot_mask_t ALL_SLOTS = '1;

  // f1 stage contents
  pc_t       pc_f1_q;
  btb_pred_t pred_f1_q;
  logic      acc_f1_q;
  logic      flush_q;
  logic      override_q;

  logic       f1_vld;
  logic       mispredict;
  slot_mask_t keep_mask;
  slot_mask_t f1_mask;

  // towards the instruction buffer
  inst_t [SLOTS-1:0] dec_words_q;
  slot_mask_t        dec_mask_q;

  ////////////////////////////////////////
  // f0 -> f1 pipe register
  ////////////////////////////////////////

  // everything holds while the instruction buffer is full
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      acc_f1_q   <= 1'b0;
      flush_q    <= 1'b0;
      override_q <= 1'b0;
    end else if (load_fetch_i) begin
      acc_f1_q   <= ~icache_stall_i;
      flush_q    <= flush_i;
      override_q <= override_vld_o;
    end
  end

  always_ff @(posedge clock) begin
    if (load_fetch_i) begin
      pc_f1_q   <= pc_f0_i;
      pred_f1_q <= pred_i;
    end
  end

  assign pc_f1_o = pc_f1_q;

  // wrong-path fetch after an override or flush is dropped
  assign f1_vld = acc_f1_q & ~flush_q & ~override_q & ~flush_i;

  ////////////////////////////////////////
  // prediction check
  ////////////////////////////////////////

  always_comb begin
    if (decode_i.found != pred_f1_q.hit) begin
      mispredict = 1'b1;
    end else if (decode_i.found) begin
      mispredict = (decode_i.pos != pred_f1_q.pos) ||
                   (decode_i.target != pred_f1_q.target);
    end else begin
      mispredict = 1'b0;
    end
  end

  assign override_vld_o = load_fetch_i & f1_vld & mispredict;

  // no branch found means f0 jumped on a stale hit, resume sequentially
  assign override_pc_o = decode_i.found ? decode_i.target
                                        : pc_f1_q + pc_t'(BUNDLE_BYTES);

  assign btb_write_o = '{
    we:     override_vld_o & decode_i.found,
    pc:     pc_f1_q,
    pos:    decode_i.pos,
    target: decode_i.target
  };

  ////////////////////////////////////////
  // f1 -> decode register
  ////////////////////////////////////////

  // keep slots up to and including the branch
  assign keep_mask = decode_i.found ? ALL_SLOTS >> (slot_t'(SLOTS - 1) - decode_i.pos)
                                    : ALL_SLOTS;
  assign f1_mask   = keep_mask & {SLOTS{f1_vld}};

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      dec_mask_q <= '0;
    end else if (load_fetch_i) begin
      dec_mask_q <= f1_mask;
    end
  end

  always_ff @(posedge clock) begin
    if (load_fetch_i) begin
      dec_words_q <= bundle_i.words;
    end
  end

  assign decode_bundle_o = '{words: dec_words_q, mask: dec_mask_q};

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                     clock,
  input  logic                     reset_n,
  // f0 pc from the pc generator
  input  fetch_pkg::pc_t           pc_f0_i,
  // icache data, valid in f1
  input  fetch_pkg::fetch_bundle_t bundle_i,
  input  logic                     icache_stall_i,
  input  logic                     instbuf_full_i,
  input  logic                     flush_i,
  // back to the pc generator
  output fetch_pkg::pc_t           next_pc_o,
  output logic                     override_vld_o,
  output fetch_pkg::pc_t           override_pc_o,
  // to the instruction buffer
  output fetch_pkg::fetch_bundle_t decode_bundle_o
);

  import fetch_pkg::*;

  logic       load_fetch;
  btb_pred_t  btb_pred;
  br_decode_t br_decode;
  btb_write_t btb_write;
  pc_t        pc_f1;

  // a flush always moves the pipe, even into a full buffer
  assign load_fetch = ~instbuf_full_i | flush_i;

  ////////////////////////////////////////
  // f0 branch target buffer
  ////////////////////////////////////////

  btb_predictor #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_btb (
    .clock       (clock),
    .reset_n     (reset_n),
    .pc_f0_i     (pc_f0_i),
    .btb_write_i (btb_write),
    .next_pc_o   (next_pc_o),
    .pred_o      (btb_pred)
  );

  ////////////////////////////////////////
  // f1 branch scan
  ////////////////////////////////////////

  branch_decoder i_brdec (
    .pc_f1_i  (pc_f1),
    .bundle_i (bundle_i),
    .decode_o (br_decode)
  );

  ////////////////////////////////////////
  // check, override and output register
  ////////////////////////////////////////

  fetch_redirect i_redirect (
    .clock           (clock),
    .reset_n         (reset_n),
    .load_fetch_i    (load_fetch),
    .flush_i         (flush_i),
    .icache_stall_i  (icache_stall_i),
    .pc_f0_i         (pc_f0_i),
    .pred_i          (btb_pred),
    .decode_i        (br_decode),
    .bundle_i        (bundle_i),
    .pc_f1_o         (pc_f1),
    .btb_write_o     (btb_write),
    .override_vld_o  (override_vld_o),
    .override_pc_o   (override_pc_o),
    .decode_bundle_o (decode_bundle_o)
  );

endmodule

/* sim/fetch_unit_props.sv */
`timescale 1ns/100ps

module fetch_unit_props (
  input logic                     clock,
  input logic                     reset_n,
  input logic                     override_vld_i,
  input fetch_pkg::pc_t           override_pc_i,
  input fetch_pkg::fetch_bundle_t decode_bundle_i
);

  import fetch_pkg::*;

  slot_mask_t dec_mask;

  assign dec_mask = decode_bundle_i.mask;

  ////////////////////////////////////////
  // output properties
  ////////////////////////////////////////

  // ones from slot 0 upwards, nothing above the first zero
  a_mask_prefix: assert property (
    @(posedge clock) disable iff (!reset_n)
    (dec_mask & (dec_mask + slot_mask_t'(1))) == '0
  ) else $error("decode mask %0h is not a prefix of slots", dec_mask);

  a_override_aligned: assert property (
    @(posedge clock) disable iff (!reset_n)
    override_vld_i |-> (override_pc_i[1:0] == 2'b00)
  ) else $error("override pc %0h not word aligned", override_pc_i);

  // nothing in f1 yet right after reset
  a_quiet_after_reset: assert property (
    @(posedge clock) $rose(reset_n) |-> !override_vld_i
  ) else $error("override raised in first cycle after reset");

endmodule

bind fetch_unit fetch_unit_props i_props (
  .clock           (clock),
  .reset_n         (reset_n),
  .override_vld_i  (override_vld_o),
  .override_pc_i   (override_pc_o),
  .decode_bundle_i (decode_bundle_o)
);

/* sim/fetch_unit_tb.sv */
`timescale 1ns/100ps

module fetch_unit_tb;

  import fetch_pkg::*;

  localparam int BTB_ENTRIES = 16;
  localparam int OFFS_W      = $clog2(BUNDLE_BYTES);
  localparam int IDX_W       = $clog2(BTB_ENTRIES);
  localparam int TAG_W       = PC_W - OFFS_W - IDX_W;
  localparam int NO_BRANCH   = -1;
  localparam int CHK_W       = $bits(fetch_bundle_t);

  typedef logic [CHK_W-1:0] chk_t;

  // one fetch per row with its words arriving a cycle later in f1
  typedef struct packed {
    pc_t               pc;
    inst_t [SLOTS-1:0] words;
    logic              stall;
    logic              full;
    logic              flush;
  } row_t;

  logic          clock;
  logic          reset_n;
  pc_t           pc_f0_i;
  fetch_bundle_t bundle_i;
  logic          icache_stall_i;
  logic          instbuf_full_i;
  logic          flush_i;
  pc_t           next_pc_o;
  logic          override_vld_o;
  pc_t           override_pc_o;
  fetch_bundle_t decode_bundle_o;

  row_t  rows [$];
  string names [$];
  int    cycle_count = 0;
  int    timeout_cycles;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  logic [BTB_ENTRIES-1:0] m_valid;
  logic [TAG_W-1:0]       m_tag [BTB_ENTRIES];
  slot_t                  m_pos [BTB_ENTRIES];
  pc_t                    m_tgt [BTB_ENTRIES];

  // fetch sitting in f1
  pc_t               f1_pc;
  logic              f1_hit;
  slot_t             f1_pos;
  pc_t               f1_ptgt;
  logic              f1_acc;
  logic              f1_flush;
  logic              f1_ovr;
  inst_t [SLOTS-1:0] f1_words;
  fetch_bundle_t     exp_dec;

  fetch_unit #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_dut (
    .clock           (clock),
    .reset_n         (reset_n),
    .pc_f0_i         (pc_f0_i),
    .bundle_i        (bundle_i),
    .icache_stall_i  (icache_stall_i),
    .instbuf_full_i  (instbuf_full_i),
    .flush_i         (flush_i),
    .next_pc_o       (next_pc_o),
    .override_vld_o  (override_vld_o),
    .override_pc_o   (override_pc_o),
    .decode_bundle_o (decode_bundle_o)
  );

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the stimulus table did not finish in %0d cycles", timeout_cycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input chk_t expected, input chk_t actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // any opcode except the two unconditional branches
  function automatic inst_t plain_word();
    inst_t w;
    w = $urandom;
    if ((w[31:26] == 6'h30) || (w[31:26] == 6'h34)) begin
      w[26] = 1'b1;
    end
    return w;
  endfunction

  task automatic add_row(input string name, input pc_t pc, input int br_slot,
                         input logic [5:0] opc, input logic [20:0] disp,
                         input logic stall, input logic full, input logic flush);
    row_t row;
    row.pc = pc;
    for (int i = 0; i < SLOTS; i++) begin
      row.words[i] = plain_word();
    end
    if (br_slot >= 0) begin
      row.words[slot_t'(br_slot)] = {opc, 5'd26, disp};
    end
    row.stall = stall;
    row.full  = full;
    row.flush = flush;
    rows.push_back(row);
    names.push_back(name);
  endtask

  // first BR/BSR in the bundle and its target of next word plus 4 * sext(disp)
  task automatic find_branch(input pc_t pc, input inst_t [SLOTS-1:0] words,
                             output logic found, output slot_t pos, output pc_t target);
    logic [20:0] disp;
    found  = 1'b0;
    pos    = '0;
    target = '0;
    for (int i = 0; i < SLOTS; i++) begin
      if (!found && ((words[i][31:26] == 6'h30) || (words[i][31:26] == 6'h34))) begin
        disp   = words[i][20:0];
        found  = 1'b1;
        pos    = slot_t'(i);
        target = pc + pc_t'(4 * (i + 1)) + (pc_t'($signed(disp)) << 2);
      end
    end
  endtask

  task automatic build_table();
    add_row("seq_0", 64'h1000, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("seq_1", 64'h1020, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("seq_2", 64'h1040, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("seq_3", 64'h1060, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    // BR in slot 3 jumps to 0x2100
    add_row("first_br", 64'h2000, 3, OPC_BR, 21'h3c, 1'b0, 1'b0, 1'b0);
    add_row("first_squash", 64'h2020, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("first_target", 64'h2100, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("trained", 64'h2000, 3, OPC_BR, 21'h3c, 1'b0, 1'b0, 1'b0);
    add_row("trained_target", 64'h2100, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("trained_seq", 64'h2120, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("false_hit", 64'h2000, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("false_wrong_path", 64'h2100, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("false_resume", 64'h2020, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    // same bundle with the branch moved to slot 5 and target 0x2060
    add_row("retrain", 64'h2000, 5, OPC_BR, 21'h12, 1'b0, 1'b0, 1'b0);
    add_row("retrain_wrong_path", 64'h2100, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("retrain_resume", 64'h2060, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("retrained", 64'h2000, 5, OPC_BR, 21'h12, 1'b0, 1'b0, 1'b0);
    add_row("retrained_target", 64'h2060, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    // backward BSR in slot 0 to 0x2fe0
    add_row("bsr_first", 64'h3000, 0, OPC_BSR, 21'h1ffff7, 1'b0, 1'b0, 1'b0);
    add_row("bsr_squash", 64'h3020, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("bsr_target", 64'h2fe0, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    // same index as 0x2000 but another tag
    add_row("alias_miss", 64'h2200, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    // BR in slot 6 to 0x2260 sits unresolved in f1 while the buffer is full
    add_row("br_before_full", 64'h2220, 6, OPC_BR, 21'h9, 1'b0, 1'b0, 1'b0);
    add_row("full_a", 64'h2240, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b1, 1'b0);
    add_row("full_b", 64'h2240, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b1, 1'b0);
    add_row("full_release", 64'h2240, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("after_full", 64'h2260, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("icache_stall", 64'h2280, NO_BRANCH, 6'h00, 21'h0, 1'b1, 1'b0, 1'b0);
    add_row("after_stall", 64'h22a0, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("flush", 64'h22c0, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b1);
    add_row("after_flush_0", 64'h22e0, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("after_flush_1", 64'h2300, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("flush_into_full", 64'h2320, 2, OPC_BR, 21'h7, 1'b0, 1'b1, 1'b1);
    add_row("after_flush_full", 64'h2340, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
    add_row("drain", 64'h2360, NO_BRANCH, 6'h00, 21'h0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic apply_row(input int r);
    row_t             row;
    string            name;
    logic             load;
    logic             hit;
    logic             f1_ok;
    logic             mismatch;
    logic             ovr;
    logic             br_found;
    slot_t            br_pos;
    slot_t            p_pos;
    pc_t              br_tgt;
    pc_t              p_tgt;
    pc_t              exp_next;
    pc_t              exp_ovr_pc;
    slot_mask_t       exp_mask;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] tag;

    row  = rows[r];
    name = names[r];
    load = ~row.full | row.flush;

    pc_f0_i        = row.pc;
    bundle_i.words = f1_words;
    bundle_i.mask  = 8'h00;
    icache_stall_i = row.stall;
    instbuf_full_i = row.full;
    flush_i        = row.flush;
    #10;

    // f0 lookup against the model BTB
    idx      = row.pc[OFFS_W +: IDX_W];
    tag      = row.pc[PC_W-1 -: TAG_W];
    hit      = m_valid[idx] && (m_tag[idx] == tag);
    p_pos    = m_pos[idx];
    p_tgt    = m_tgt[idx];
    exp_next = hit ? p_tgt : row.pc + pc_t'(BUNDLE_BYTES);

    // f1 decode and compare
    find_branch(f1_pc, f1_words, br_found, br_pos, br_tgt);
    f1_ok    = f1_acc && !f1_flush && !f1_ovr && !row.flush;
    mismatch = (br_found != f1_hit) ||
               (br_found && ((br_pos != f1_pos) || (br_tgt != f1_ptgt)));
    ovr      = load && f1_ok && mismatch;
    exp_ovr_pc = br_found ? br_tgt : f1_pc + pc_t'(BUNDLE_BYTES);
    for (int i = 0; i < SLOTS; i++) begin
      exp_mask[i] = f1_ok && (!br_found || (i <= int'(br_pos)));
    end

    check_value({name, " next_pc_o"}, chk_t'(exp_next), chk_t'(next_pc_o));
    check_value({name, " override_vld_o"}, chk_t'(ovr), chk_t'(override_vld_o));
    if (ovr) begin
      check_value({name, " override_pc_o"}, chk_t'(exp_ovr_pc), chk_t'(override_pc_o));
    end
    check_value({name, " decode mask"}, chk_t'(exp_dec.mask), chk_t'(decode_bundle_o.mask));
    if (exp_dec.mask != '0) begin
      check_value({name, " decode bundle"}, chk_t'(exp_dec), chk_t'(decode_bundle_o));
    end

    // state as it stands after the next rising edge
    if (ovr && br_found) begin
      wr_idx          = f1_pc[OFFS_W +: IDX_W];
      m_valid[wr_idx] = 1'b1;
      m_tag[wr_idx]   = f1_pc[PC_W-1 -: TAG_W];
      m_pos[wr_idx]   = br_pos;
      m_tgt[wr_idx]   = br_tgt;
    end
    if (load) begin
      exp_dec.mask  = exp_mask;
      exp_dec.words = f1_words;
      f1_acc   = ~row.stall;
      f1_flush = row.flush;
      f1_ovr   = ovr;
      f1_pc    = row.pc;
      f1_hit   = hit;
      f1_pos   = p_pos;
      f1_ptgt  = p_tgt;
      f1_words = row.words;
    end
  endtask

  initial begin
    clock          = 1'b0;
    reset_n        = 1'b0;
    pc_f0_i        = '0;
    bundle_i       = '0;
    icache_stall_i = 1'b0;
    instbuf_full_i = 1'b0;
    flush_i        = 1'b0;
    void'($urandom(32'hc732_4019));

    m_valid = '0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_tag[i] = '0;
      m_pos[i] = '0;
      m_tgt[i] = '0;
    end
    // registers without reset load zeros while reset is held
    f1_pc    = '0;
    f1_hit   = 1'b0;
    f1_pos   = '0;
    f1_ptgt  = '0;
    f1_acc   = 1'b0;
    f1_flush = 1'b0;
    f1_ovr   = 1'b0;
    f1_words = '0;
    exp_dec  = '0;

    build_table();
    timeout_cycles = 4 * rows.size() + 20;

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    for (int r = 0; r < rows.size(); r++) begin
      apply_row(r);
      @(negedge clock);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* filelist.f */
common/fetch_pkg.sv
btb/btb_predictor.sv
hdl/branch_decoder.sv
hdl/fetch_redirect.sv
hdl/fetch_unit.sv
sim/fetch_unit_props.sv
sim/fetch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module fetch_unit_tb \
  -f filelist.f \
  -o fetch_unit_sim

sim_out=$(./obj_dir/fetch_unit_sim 2>&1 || true)
echo "$sim_out"

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
  exit 0
fi
exit 1
